//--- vldu_pkg.sv
////////////////////
// Vector load unit shared definitions
// Widths, vector types and packed structs used across the load path
////////////////////
`default_nettype none

package vldu_pkg;

  ////////////////////
  // Sizes
  ////////////////////

  // Vector register length in bits
  localparam int unsigned Vlen             = 1024;
  // Bytes in one lane element
  localparam int unsigned ElenBytes        = 8;
  // Number of instruction ids
  localparam int unsigned NrVInsn          = 8;
  // Instructions held in flight
  localparam int unsigned InsnQueueDepth   = 4;
  // Finished register-file words buffered
  localparam int unsigned ResultQueueDepth = 2;

  ////////////////////
  // Vector types
  ////////////////////

  typedef logic [8*ElenBytes-1:0]     elen_t;
  typedef logic [ElenBytes-1:0]       strb_t;
  typedef logic [$clog2(NrVInsn)-1:0] vid_t;
  // Word address inside one lane's register file
  typedef logic [9:0]                 vaddr_t;
  typedef logic [7:0]                 vl_t;
  // 0 to 3 select 8 to 64 bit elements
  typedef logic [1:0]                 vsew_t;
  typedef logic [4:0]                 vreg_t;

  ////////////////////
  // Structs
  ////////////////////

  // Load instruction from the sequencer
  typedef struct packed {
    vid_t  id;
    vreg_t vd;
    vl_t   vl;
    vsew_t vsew;
    // Unmasked when high
    logic  vm;
  } pe_req_t;

  // One write into one lane
  typedef struct packed {
    vid_t   id;
    vaddr_t addr;
    elen_t  wdata;
    strb_t  be;
  } lane_payload_t;

  // R channel beat, sized for the default 64-bit bus
  typedef struct packed {
    logic [63:0] data;
    logic        last;
  } r_beat_t;

  // First word of a vector register within each lane
  function automatic vaddr_t vreg_base(vreg_t vreg, int unsigned nr_lanes);
    int unsigned words_per_reg;
    words_per_reg = Vlen / (8 * ElenBytes * nr_lanes);
    return vaddr_t'(vreg * words_per_reg);
  endfunction

endpackage

`default_nettype wire

//--- vldu_insn_queue.sv
////////////////////
// Load instruction queue
// Holds accepted loads in order, exposes the issue head, retires the commit head
////////////////////
`timescale 1ns/100ps
`default_nettype none

module vldu_insn_queue (
  input  logic              clk_i,
  input  logic              rst_ni,
  // Sequencer side
  input  vldu_pkg::pe_req_t pe_req_i,
  input  logic              pe_req_valid_i,
  output logic              pe_req_ready_o,
  // Issue head towards the packer
  output vldu_pkg::pe_req_t issue_insn_o,
  output logic              issue_valid_o,
  input  logic              issue_done_i,
  // Commit side
  input  logic              commit_done_i,
  output logic              pe_done_o,
  output vldu_pkg::vid_t    pe_done_id_o
);

  localparam int unsigned Depth = vldu_pkg::InsnQueueDepth;
  localparam int unsigned PntW  = (Depth > 1) ? $clog2(Depth) : 1;
  localparam int unsigned CntW  = $clog2(Depth) + 1;

  // Instruction store
  vldu_pkg::pe_req_t insn_q [Depth];

  // Three phase pointers
  logic [PntW-1:0] accept_pnt_q;
  logic [PntW-1:0] issue_pnt_q;
  logic [PntW-1:0] commit_pnt_q;

  // Waiting to issue, and waiting to commit
  logic [CntW-1:0] issue_cnt_q;
  logic [CntW-1:0] issue_cnt_d;
  logic [CntW-1:0] commit_cnt_q;
  logic [CntW-1:0] commit_cnt_d;

  logic           ready_q;
  logic           accept;
  logic           done_q;
  vldu_pkg::vid_t done_id_q;

  // Circular pointer step
  function automatic logic [PntW-1:0] bump(logic [PntW-1:0] pnt);
    return (pnt == PntW'(Depth - 1)) ? '0 : pnt + PntW'(1);
  endfunction

  ////////////////////
  // Handshakes
  ////////////////////

  assign accept         = pe_req_valid_i && ready_q;
  assign pe_req_ready_o = ready_q;

  // Head is visible one cycle after accept
  assign issue_insn_o  = insn_q[issue_pnt_q];
  assign issue_valid_o = (issue_cnt_q != '0);

  assign pe_done_o    = done_q;
  assign pe_done_id_o = done_id_q;

  // Count updates
  always_comb begin
    issue_cnt_d  = issue_cnt_q;
    commit_cnt_d = commit_cnt_q;
    if (accept) begin
      issue_cnt_d  = issue_cnt_d + CntW'(1);
      commit_cnt_d = commit_cnt_d + CntW'(1);
    end
    if (issue_done_i) begin
      issue_cnt_d = issue_cnt_d - CntW'(1);
    end
    if (commit_done_i) begin
      commit_cnt_d = commit_cnt_d - CntW'(1);
    end
  end

  ////////////////////
  // State
  ////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      accept_pnt_q <= '0;
      issue_pnt_q  <= '0;
      commit_pnt_q <= '0;
      issue_cnt_q  <= '0;
      commit_cnt_q <= '0;
      ready_q      <= 1'b0;
      done_q       <= 1'b0;
      done_id_q    <= '0;
    end else begin
      issue_cnt_q  <= issue_cnt_d;
      commit_cnt_q <= commit_cnt_d;
      // Ready whenever the queue will not be full
      ready_q      <= (commit_cnt_d != CntW'(Depth));
      if (accept) begin
        accept_pnt_q <= bump(accept_pnt_q);
      end
      if (issue_done_i) begin
        issue_pnt_q <= bump(issue_pnt_q);
      end
      // Retire commit head and report its id next cycle
      done_q <= commit_done_i;
      if (commit_done_i) begin
        done_id_q    <= insn_q[commit_pnt_q].id;
        commit_pnt_q <= bump(commit_pnt_q);
      end
    end
  end

  // Store the new instruction at the accept slot
  always_ff @(posedge clk_i) begin
    if (accept) begin
      insn_q[accept_pnt_q] <= pe_req_i;
    end
  end

endmodule

`default_nettype wire

//--- vldu_beat_packer.sv
////////////////////
// R beat packer
// Packs R channel bytes into register-file words, applies the mask, tracks bytes left
////////////////////
`timescale 1ns/100ps
`default_nettype none

module vldu_beat_packer #(
  parameter int unsigned NrLanes      = 2,
  parameter int unsigned AxiDataWidth = 64
) (
  input  logic                                  clk_i,
  input  logic                                  rst_ni,
  // Issue head
  input  vldu_pkg::pe_req_t                     issue_insn_i,
  input  logic                                  issue_valid_i,
  output logic                                  issue_done_o,
  // Memory R channel
  input  vldu_pkg::r_beat_t                     r_beat_i,
  input  logic                                  r_valid_i,
  output logic                                  r_ready_o,
  // Mask unit
  input  vldu_pkg::strb_t         [NrLanes-1:0] mask_i,
  input  logic                                  mask_valid_i,
  output logic                                  mask_ready_o,
  // Result queue
  input  logic                                  rq_full_i,
  output logic                                  push_o,
  output vldu_pkg::lane_payload_t [NrLanes-1:0] push_payload_o,
  output logic                                  push_last_o
);

  localparam int unsigned ElenB     = vldu_pkg::ElenBytes;
  localparam int unsigned WordBytes = NrLanes * ElenB;
  localparam int unsigned BeatBytes = AxiDataWidth / 8;
  // Wide enough to hold WordBytes itself
  localparam int unsigned PntW      = $clog2(WordBytes) + 1;
  // vl shifted by up to 3
  localparam int unsigned CntW      = $bits(vldu_pkg::vl_t) + 3;

  // Byte counters
  logic            fresh_q;
  logic [CntW-1:0] bytes_left_q;
  logic [CntW-1:0] total_bytes;
  logic [CntW-1:0] cur_left;
  logic [CntW-1:0] taken;
  logic [PntW-1:0] byte_pnt_q;
  logic [PntW-1:0] next_pnt;
  vldu_pkg::vaddr_t word_idx_q;
  vldu_pkg::vaddr_t base_addr;

  // Partial word from earlier beats
  vldu_pkg::elen_t [NrLanes-1:0] wdata_q;
  vldu_pkg::elen_t [NrLanes-1:0] wdata_d;
  vldu_pkg::strb_t [NrLanes-1:0] be_q;
  vldu_pkg::strb_t [NrLanes-1:0] be_d;

  logic fire;
  logic insn_last;
  logic word_done;

  ////////////////////
  // Beat accounting
  ////////////////////

  always_comb begin
    // Bytes of the instruction in total
    total_bytes = CntW'(issue_insn_i.vl) << issue_insn_i.vsew;
    // A fresh head starts with its full byte count
    cur_left    = fresh_q ? total_bytes : bytes_left_q;
    insn_last   = (cur_left <= CntW'(BeatBytes));
    taken       = insn_last ? cur_left : CntW'(BeatBytes);
    next_pnt    = byte_pnt_q + PntW'(taken);
    word_done   = insn_last || (next_pnt == PntW'(WordBytes));
  end

  // Need a head, room in the result queue, and a mask flit when masked
  assign r_ready_o    = issue_valid_i && !rq_full_i && (issue_insn_i.vm || mask_valid_i);
  assign fire         = r_valid_i && r_ready_o;
  assign push_o       = fire && word_done;
  assign push_last_o  = insn_last;
  assign issue_done_o = fire && insn_last;
  // One mask flit per word
  assign mask_ready_o = fire && word_done && !issue_insn_i.vm;

  ////////////////////
  // Byte placement
  ////////////////////

  always_comb begin
    wdata_d   = '0;
    be_d      = '0;
    base_addr = vldu_pkg::vreg_base(issue_insn_i.vd, NrLanes);
    for (int unsigned wb = 0; wb < WordBytes; wb++) begin : l_byte
      automatic int unsigned lane = wb / ElenB;
      automatic int unsigned off  = wb % ElenB;
      automatic int unsigned rel  = wb - byte_pnt_q;
      if (wb < byte_pnt_q) begin
        // Already filled by an earlier beat
        wdata_d[lane][8*off +: 8] = wdata_q[lane][8*off +: 8];
        be_d[lane][off]           = be_q[lane][off];
      end else if ((rel < BeatBytes) && (rel < cur_left)) begin
        // In order copy, word byte b lands in lane b/8
        wdata_d[lane][8*off +: 8] = r_beat_i.data[8*rel +: 8];
        be_d[lane][off]           = issue_insn_i.vm || mask_i[lane][off];
      end
      // Bytes past the end stay zero with no enable
    end
    for (int unsigned l = 0; l < NrLanes; l++) begin : l_lane
      push_payload_o[l].id    = issue_insn_i.id;
      push_payload_o[l].addr  = base_addr + word_idx_q;
      push_payload_o[l].wdata = wdata_d[l];
      push_payload_o[l].be    = be_d[l];
    end
  end

  ////////////////////
  // State
  ////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      fresh_q      <= 1'b1;
      bytes_left_q <= '0;
      byte_pnt_q   <= '0;
      word_idx_q   <= '0;
    end else if (fire) begin
      // Next head gets loaded after the final beat
      fresh_q      <= insn_last;
      bytes_left_q <= cur_left - taken;
      byte_pnt_q   <= word_done ? '0 : next_pnt;
      if (insn_last) begin
        word_idx_q <= '0;
      end else if (word_done) begin
        word_idx_q <= word_idx_q + 1'b1;
      end
    end
  end

  // Partial word storage
  always_ff @(posedge clk_i) begin
    if (fire) begin
      wdata_q <= wdata_d;
      be_q    <= be_d;
    end
  end

endmodule

`default_nettype wire

//--- vldu_result_queue.sv
////////////////////
// Result queue
// Two finished words, per-lane write requests held until each lane grants
////////////////////
`timescale 1ns/100ps
`default_nettype none

module vldu_result_queue #(
  parameter int unsigned NrLanes = 2
) (
  input  logic                                  clk_i,
  input  logic                                  rst_ni,
  // Packer side
  input  logic                                  push_i,
  input  vldu_pkg::lane_payload_t [NrLanes-1:0] push_payload_i,
  input  logic                                  push_last_i,
  output logic                                  full_o,
  // Lanes
  output logic                    [NrLanes-1:0] lane_req_o,
  output vldu_pkg::lane_payload_t [NrLanes-1:0] lane_payload_o,
  input  logic                    [NrLanes-1:0] lane_gnt_i,
  // Instruction queue
  output logic                                  commit_done_o
);

  localparam int unsigned Depth = vldu_pkg::ResultQueueDepth;
  localparam int unsigned PntW  = (Depth > 1) ? $clog2(Depth) : 1;
  localparam int unsigned CntW  = $clog2(Depth) + 1;

  // Entry payloads
  vldu_pkg::lane_payload_t [Depth-1:0][NrLanes-1:0] entry_q;

  // Per-lane outstanding requests, and the last word flag
  logic [Depth-1:0][NrLanes-1:0] valid_q;
  logic [Depth-1:0][NrLanes-1:0] valid_d;
  logic [Depth-1:0]              last_q;

  logic [PntW-1:0] rd_pnt_q;
  logic [PntW-1:0] wr_pnt_q;
  logic [CntW-1:0] cnt_q;
  logic [CntW-1:0] cnt_d;
  logic            leave;

  assign full_o = (cnt_q == CntW'(Depth));

  ////////////////////
  // Lane writes
  ////////////////////

  always_comb begin
    valid_d = valid_q;
    // Read head drives every lane
    for (int unsigned l = 0; l < NrLanes; l++) begin : l_lane
      lane_req_o[l]     = valid_q[rd_pnt_q][l];
      lane_payload_o[l] = entry_q[rd_pnt_q][l];
      // A grant drops that lane's request
      if (lane_req_o[l] && lane_gnt_i[l]) begin
        valid_d[rd_pnt_q][l] = 1'b0;
      end
    end
    // Head leaves with its last outstanding grant
    leave         = (cnt_q != '0) && !(|valid_d[rd_pnt_q]);
    commit_done_o = leave && last_q[rd_pnt_q];
    // New word requests on every lane from the next cycle
    if (push_i) begin
      valid_d[wr_pnt_q] = '1;
    end
    cnt_d = cnt_q + CntW'(push_i) - CntW'(leave);
  end

  ////////////////////
  // State
  ////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q  <= '0;
      last_q   <= '0;
      rd_pnt_q <= '0;
      wr_pnt_q <= '0;
      cnt_q    <= '0;
    end else begin
      valid_q <= valid_d;
      cnt_q   <= cnt_d;
      if (push_i) begin
        last_q[wr_pnt_q] <= push_last_i;
        wr_pnt_q         <= (wr_pnt_q == PntW'(Depth - 1)) ? '0 : wr_pnt_q + PntW'(1);
      end
      if (leave) begin
        rd_pnt_q <= (rd_pnt_q == PntW'(Depth - 1)) ? '0 : rd_pnt_q + PntW'(1);
      end
    end
  end

  // Word payload capture
  always_ff @(posedge clk_i) begin
    if (push_i) begin
      entry_q[wr_pnt_q] <= push_payload_i;
    end
  end

endmodule

`default_nettype wire

//--- vldu_top.sv
////////////////////
// Vector load unit top
// Instruction queue, beat packer and result queue of the load path
////////////////////
`timescale 1ns/100ps
`default_nettype none

module vldu_top #(
  parameter int unsigned NrLanes      = 2,
  parameter int unsigned AxiDataWidth = 64
) (
  input  logic                                  clk_i,
  input  logic                                  rst_ni,
  // Sequencer
  input  vldu_pkg::pe_req_t                     pe_req_i,
  input  logic                                  pe_req_valid_i,
  output logic                                  pe_req_ready_o,
  output logic                                  pe_done_o,
  output vldu_pkg::vid_t                        pe_done_id_o,
  // Memory R channel
  input  vldu_pkg::r_beat_t                     r_beat_i,
  input  logic                                  r_valid_i,
  output logic                                  r_ready_o,
  // Mask unit
  input  vldu_pkg::strb_t         [NrLanes-1:0] mask_i,
  input  logic                                  mask_valid_i,
  output logic                                  mask_ready_o,
  // Lanes
  output logic                    [NrLanes-1:0] lane_req_o,
  output vldu_pkg::lane_payload_t [NrLanes-1:0] lane_payload_o,
  input  logic                    [NrLanes-1:0] lane_gnt_i
);

  // Issue head and its handshake
  vldu_pkg::pe_req_t issue_insn;
  logic              issue_valid;
  logic              issue_done;

  // Word writes into the result queue
  logic                                  push;
  vldu_pkg::lane_payload_t [NrLanes-1:0] push_payload;
  logic                                  push_last;
  logic                                  rq_full;

  // Last word of an instruction has left
  logic commit_done;

  ////////////////////
  // Instances
  ////////////////////

  vldu_insn_queue i_insn_queue (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .pe_req_i       (pe_req_i),
    .pe_req_valid_i (pe_req_valid_i),
    .pe_req_ready_o (pe_req_ready_o),
    .issue_insn_o   (issue_insn),
    .issue_valid_o  (issue_valid),
    .issue_done_i   (issue_done),
    .commit_done_i  (commit_done),
    .pe_done_o      (pe_done_o),
    .pe_done_id_o   (pe_done_id_o)
  );

  vldu_beat_packer #(
    .NrLanes      (NrLanes),
    .AxiDataWidth (AxiDataWidth)
  ) i_beat_packer (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .issue_insn_i   (issue_insn),
    .issue_valid_i  (issue_valid),
    .issue_done_o   (issue_done),
    .r_beat_i       (r_beat_i),
    .r_valid_i      (r_valid_i),
    .r_ready_o      (r_ready_o),
    .mask_i         (mask_i),
    .mask_valid_i   (mask_valid_i),
    .mask_ready_o   (mask_ready_o),
    .rq_full_i      (rq_full),
    .push_o         (push),
    .push_payload_o (push_payload),
    .push_last_o    (push_last)
  );

  vldu_result_queue #(
    .NrLanes (NrLanes)
  ) i_result_queue (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .push_i         (push),
    .push_payload_i (push_payload),
    .push_last_i    (push_last),
    .full_o         (rq_full),
    .lane_req_o     (lane_req_o),
    .lane_payload_o (lane_payload_o),
    .lane_gnt_i     (lane_gnt_i),
    .commit_done_o  (commit_done)
  );

endmodule

`default_nettype wire

//--- vldu_asserts.sv
////////////////////
// Load unit handshake checks
// Bound into the top level
////////////////////
`timescale 1ns/100ps
`default_nettype none

module vldu_asserts #(
  parameter int unsigned NrLanes = 2
) (
  input logic                                  clk_i,
  input logic                                  rst_ni,
  input logic                                  r_ready_i,
  // Outstanding lane writes of each result entry
  input logic [vldu_pkg::ResultQueueDepth-1:0][NrLanes-1:0] rq_valid_i,
  input logic                                  pe_done_i,
  input logic                    [NrLanes-1:0] lane_req_i,
  input vldu_pkg::lane_payload_t [NrLanes-1:0] lane_payload_i,
  input logic                    [NrLanes-1:0] lane_gnt_i
);

  logic rq_full;

  // An occupied entry always owes at least one lane write
  always_comb begin
    rq_full = 1'b1;
    for (int e = 0; e < vldu_pkg::ResultQueueDepth; e++) begin
      rq_full = rq_full && (|rq_valid_i[e]);
    end
  end

  // Memory stalls while both result entries are taken
  a_stall_on_full: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    rq_full |-> !r_ready_i
  ) else $error("r_ready_o high while the result queue is full");

  // Completion is a one-cycle pulse
  a_done_pulse: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    pe_done_i |=> !pe_done_i
  ) else $error("pe_done_o high for more than one cycle");

  ////////////////////
  // Per lane
  ////////////////////

  for (genvar l = 0; l < NrLanes; l++) begin : g_lane
    // Request and payload hold until the grant
    a_payload_hold: assert property (
      @(posedge clk_i) disable iff (!rst_ni)
      lane_req_i[l] && !lane_gnt_i[l] |=> lane_req_i[l] && $stable(lane_payload_i[l])
    ) else $error("Lane %0d request or payload changed before its grant", l);
  end

endmodule

`default_nettype wire

//--- tb_vldu.sv
////////////////////
// Load unit testbench
// Directed loads with lane models, completion tracking and a watchdog
////////////////////
`timescale 1ns/100ps
`default_nettype none

module tb_vldu;

  localparam int unsigned NrLanes       = 2;
  localparam int unsigned AxiDataWidth  = 64;
  localparam int unsigned WordBytes     = NrLanes * 8;
  // Register-file words per vector register in one lane
  localparam int unsigned WordsPerReg   = vldu_pkg::Vlen / (64 * NrLanes);
  localparam int          ClkPeriod     = 20;
  localparam int          DriveDelay    = 2;
  localparam int          MaxGrantDelay = 3;
  // Beats over all tests, rounded up
  localparam int          TotalBeats    = 40;
  localparam int          TimeoutNs     = (TotalBeats * (MaxGrantDelay + 1) * 4 + 100) * ClkPeriod;

  logic                                  clk_i;
  logic                                  rst_ni;
  vldu_pkg::pe_req_t                     pe_req_i;
  logic                                  pe_req_valid_i;
  logic                                  pe_req_ready_o;
  logic                                  pe_done_o;
  vldu_pkg::vid_t                        pe_done_id_o;
  vldu_pkg::r_beat_t                     r_beat_i;
  logic                                  r_valid_i;
  logic                                  r_ready_o;
  vldu_pkg::strb_t         [NrLanes-1:0] mask_i;
  logic                                  mask_valid_i;
  logic                                  mask_ready_o;
  logic                    [NrLanes-1:0] lane_req_o;
  vldu_pkg::lane_payload_t [NrLanes-1:0] lane_payload_o;
  logic                    [NrLanes-1:0] lane_gnt_i;

  int                      errors = 0;
  int                      seed   = 32'h8211;
  // Ids waiting for completion, in acceptance order
  vldu_pkg::vid_t          exp_ids [$];
  // Writes each lane should see, and the data bytes that matter
  vldu_pkg::lane_payload_t exp_q   [NrLanes][$];
  vldu_pkg::strb_t         care_q  [NrLanes][$];

  vldu_top #(
    .NrLanes      (NrLanes),
    .AxiDataWidth (AxiDataWidth)
  ) DUT (.*);

  bind vldu_top vldu_asserts #(.NrLanes(NrLanes)) i_asserts (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .r_ready_i      (r_ready_o),
    .rq_valid_i     (i_result_queue.valid_q),
    .pe_done_i      (pe_done_o),
    .lane_req_i     (lane_req_o),
    .lane_payload_i (lane_payload_o),
    .lane_gnt_i     (lane_gnt_i)
  );

  initial begin : clock_gen
    clk_i = 1'b0;
    forever #(ClkPeriod / 2) clk_i = ~clk_i;
  end

  initial begin : watchdog
    #(TimeoutNs);
    $display("Watchdog expired after %0d ns, the load unit stopped making progress", TimeoutNs);
    $display("TEST RESULT: FAIL");
    $finish;
  end

  ////////////////////
  // Compare tasks
  ////////////////////

  task automatic check_payload(input int lane, input vldu_pkg::lane_payload_t got,
                               input vldu_pkg::lane_payload_t exp, input vldu_pkg::strb_t care);
    vldu_pkg::elen_t dmask;
    for (int k = 0; k < 8; k++) begin
      dmask[8*k +: 8] = {8{care[k]}};
    end
    if ((got.id !== exp.id) || (got.addr !== exp.addr) || (got.be !== exp.be) ||
        ((got.wdata & dmask) !== (exp.wdata & dmask))) begin
      errors++;
      $display("ERR %0t: lane %0d got id %0d addr %0d data %h be %b", $time, lane,
               got.id, got.addr, got.wdata, got.be);
      $display("ERR %0t: lane %0d expected id %0d addr %0d data %h be %b", $time, lane,
               exp.id, exp.addr, exp.wdata & dmask, exp.be);
    end
  endtask

  task automatic check_id(input vldu_pkg::vid_t got, input vldu_pkg::vid_t exp);
    if (got !== exp) begin
      errors++;
      $display("ERR %0t: completion id %0d, expected %0d", $time, got, exp);
    end
  endtask

  ////////////////////
  // Lane and completion models
  ////////////////////

  // Each lane grants 0 to 3 cycles after its request rises
  initial begin : lane_model
    int delay [NrLanes];
    lane_gnt_i = '0;
    for (int l = 0; l < NrLanes; l++) begin
      delay[l] = -1;
    end
    forever begin
      @(posedge clk_i);
      #DriveDelay;
      for (int l = 0; l < NrLanes; l++) begin
        if (lane_gnt_i[l]) begin
          // Grant taken at this edge, idle one cycle
          lane_gnt_i[l] = 1'b0;
          delay[l]      = -1;
        end else if (lane_req_o[l]) begin
          if (delay[l] < 0) begin
            delay[l] = $unsigned($random(seed)) % (MaxGrantDelay + 1);
          end
          if (delay[l] == 0) begin
            lane_gnt_i[l] = 1'b1;
            if (exp_q[l].size() == 0) begin
              errors++;
              $display("Lane %0d received a write that no load produced", l);
            end else begin
              check_payload(l, lane_payload_o[l], exp_q[l].pop_front(), care_q[l].pop_front());
            end
          end else begin
            delay[l]--;
          end
        end
      end
    end
  end

  initial begin : done_model
    forever begin
      @(negedge clk_i);
      if (rst_ni && pe_done_o) begin
        if (exp_ids.size() == 0) begin
          errors++;
          $display("Completion pulse for id %0d with no load outstanding", pe_done_id_o);
        end else begin
          check_id(pe_done_id_o, exp_ids.pop_front());
        end
      end
    end
  end

  ////////////////////
  // Stimulus helpers
  ////////////////////

  task automatic next_cycle();
    @(posedge clk_i);
    #DriveDelay;
  endtask

  function automatic int pending_words();
    int n;
    n = 0;
    for (int l = 0; l < NrLanes; l++) begin
      n += exp_q[l].size();
    end
    return n;
  endfunction

  task automatic wait_idle();
    while ((exp_ids.size() != 0) || (pending_words() != 0)) begin
      next_cycle();
    end
  endtask

  function automatic vldu_pkg::pe_req_t make_req(int id, int vd, int vl, int vsew, bit vm);
    vldu_pkg::pe_req_t req;
    req.id   = vldu_pkg::vid_t'(id);
    req.vd   = vldu_pkg::vreg_t'(vd);
    req.vl   = vldu_pkg::vl_t'(vl);
    req.vsew = vldu_pkg::vsew_t'(vsew);
    req.vm   = vm;
    return req;
  endfunction

  // Holds the request until the queue takes it
  task automatic send_req(input vldu_pkg::pe_req_t req);
    bit hs;
    pe_req_i       = req;
    pe_req_valid_i = 1'b1;
    do begin
      @(negedge clk_i);
      hs = pe_req_ready_o;
      next_cycle();
    end while (!hs);
    pe_req_valid_i = 1'b0;
    exp_ids.push_back(req.id);
  endtask

  // Random beats and mask flits for one load, expected lane writes built first
  task automatic drive_load(input vldu_pkg::pe_req_t req, input bit gaps);
    int unsigned                   nbytes;
    int unsigned                   nbeats;
    int unsigned                   nwords;
    int unsigned                   g;
    int unsigned                   gap;
    int unsigned                   used;
    bit                            hs;
    logic [31:0]                   rnd;
    logic [63:0]                   bd;
    logic [63:0]                   data [$];
    vldu_pkg::strb_t [NrLanes-1:0] flit;
    vldu_pkg::strb_t [NrLanes-1:0] flits [$];
    vldu_pkg::lane_payload_t       exp;
    vldu_pkg::strb_t               care;
    nbytes = 32'(req.vl) << req.vsew;
    nbeats = (nbytes + 7) / 8;
    nwords = (nbytes + WordBytes - 1) / WordBytes;
    for (int b = 0; b < nbeats; b++) begin
      bd = {$random(seed), $random(seed)};
      data.push_back(bd);
    end
    for (int w = 0; w < nwords; w++) begin
      for (int l = 0; l < NrLanes; l++) begin
        rnd     = $random(seed);
        flit[l] = rnd[7:0];
      end
      flits.push_back(flit);
    end
    // Word byte b goes to lane b/8, byte b mod 8
    for (int w = 0; w < nwords; w++) begin
      flit = flits[w];
      for (int l = 0; l < NrLanes; l++) begin
        exp.id    = req.id;
        exp.addr  = vldu_pkg::vaddr_t'(req.vd * WordsPerReg + w);
        exp.wdata = '0;
        exp.be    = '0;
        care      = '0;
        for (int k = 0; k < 8; k++) begin
          g = w * WordBytes + l * 8 + k;
          if (g < nbytes) begin
            bd                  = data[g / 8];
            exp.wdata[8*k +: 8] = bd[8*(g % 8) +: 8];
            exp.be[k]           = req.vm || flit[l][k];
            care[k]             = 1'b1;
          end
        end
        exp_q[l].push_back(exp);
        care_q[l].push_back(care);
      end
    end
    used         = 0;
    mask_valid_i = !req.vm;
    for (int b = 0; b < nbeats; b++) begin
      if (gaps) begin
        gap = $unsigned($random(seed)) % 3;
        repeat (gap) next_cycle();
      end
      r_beat_i.data = data[b];
      r_beat_i.last = (b == nbeats - 1);
      r_valid_i     = 1'b1;
      mask_i        = flits[(b * 8) / WordBytes];
      do begin
        @(negedge clk_i);
        hs = r_ready_o;
        if (hs && mask_ready_o) begin
          used++;
        end
        next_cycle();
      end while (!hs);
      r_valid_i = 1'b0;
    end
    mask_valid_i = 1'b0;
    if (used != (req.vm ? 0 : nwords)) begin
      errors++;
      $display("ERR %0t: id %0d took %0d mask flits, expected %0d", $time, req.id, used,
               req.vm ? 0 : nwords);
    end
  endtask

  ////////////////////
  // Directed tests
  ////////////////////

  task automatic load_unmasked();
    vldu_pkg::pe_req_t req;
    req = make_req(1, 4, 4, 3, 1'b1);
    send_req(req);
    drive_load(req, 1'b0);
    wait_idle();
  endtask

  // Five bytes, lane 1 gets no enables
  task automatic load_partial_word();
    vldu_pkg::pe_req_t req;
    req = make_req(2, 7, 5, 0, 1'b1);
    send_req(req);
    drive_load(req, 1'b0);
    wait_idle();
  endtask

  task automatic load_masked();
    vldu_pkg::pe_req_t req;
    req = make_req(3, 2, 4, 3, 1'b0);
    send_req(req);
    drive_load(req, 1'b0);
    wait_idle();
  endtask

  task automatic load_with_stalls();
    vldu_pkg::pe_req_t req_a;
    vldu_pkg::pe_req_t req_b;
    req_a = make_req(4, 1, 8, 3, 1'b1);
    req_b = make_req(5, 9, 12, 2, 1'b0);
    send_req(req_a);
    send_req(req_b);
    drive_load(req_a, 1'b1);
    drive_load(req_b, 1'b1);
    wait_idle();
  endtask

  // Four loads fill the queue, the fifth waits for the first commit
  task automatic fill_insn_queue();
    vldu_pkg::pe_req_t reqs [5];
    for (int i = 0; i < 5; i++) begin
      reqs[i] = make_req((6 + i) % 8, 10 + i, 2, 3, 1'b1);
    end
    for (int i = 0; i < 4; i++) begin
      send_req(reqs[i]);
    end
    @(negedge clk_i);
    if (pe_req_ready_o !== 1'b0) begin
      errors++;
      $display("ERR %0t: pe_req_ready_o high with four loads queued", $time);
    end
    next_cycle();
    fork
      send_req(reqs[4]);
      begin
        for (int i = 0; i < 5; i++) begin
          drive_load(reqs[i], 1'b0);
        end
      end
    join
    wait_idle();
  endtask

  initial begin : main
    rst_ni         = 1'b0;
    pe_req_i       = '0;
    pe_req_valid_i = 1'b0;
    r_beat_i       = '0;
    r_valid_i      = 1'b0;
    mask_i         = '0;
    mask_valid_i   = 1'b0;
    repeat (3) @(posedge clk_i);
    #DriveDelay;
    rst_ni = 1'b1;
    next_cycle();
    load_unmasked();
    load_partial_word();
    load_masked();
    load_with_stalls();
    fill_insn_queue();
    $display("Load unit tests finished with %0d errors", errors);
    if (errors == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- verilog.f
vldu_pkg.sv
vldu_insn_queue.sv
vldu_beat_packer.sv
vldu_result_queue.sv
vldu_top.sv
vldu_asserts.sv
tb_vldu.sv

//--- run_sim.sh
#!/bin/sh
# Compile and run the vector load unit testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
BUILD=obj_dir

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_vldu -Mdir "$BUILD" -f verilog.f
if [ $? -ne 0 ]; then
  echo "Verilator compile failed"
  exit 1
fi

"./$BUILD/Vtb_vldu" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "^TEST RESULT: PASS$" "$LOG"; then
  exit 0
fi
echo "Pass message not found in $LOG"
exit 1
